// ==== logic/rename_cfg_pkg.sv ====
/*
 * Sizes of the architectural and physical register spaces, the free list
 * and the graduation list, with the index types built from them.
 * Imported by every RTL module of the rename back end.
 */

`default_nettype none

package rename_cfg_pkg;

    // Register spaces
    localparam int NUM_ARCH_REGS   = 32;
    localparam int NUM_PHYS_REGS   = 48;
    localparam int FREE_LIST_DEPTH = NUM_PHYS_REGS - NUM_ARCH_REGS;

    // Graduation list and datapath
    localparam int GL_DEPTH = 16;
    localparam int XLEN     = 64;

    localparam int REG_W    = $clog2(NUM_ARCH_REGS);
    localparam int PHREG_W  = $clog2(NUM_PHYS_REGS);
    localparam int GL_IDX_W = $clog2(GL_DEPTH);
    localparam int FL_PTR_W = $clog2(FREE_LIST_DEPTH);

    typedef logic [REG_W-1:0]    reg_t;
    typedef logic [PHREG_W-1:0]  phreg_t;
    typedef logic [GL_IDX_W-1:0] gl_index_t;
    typedef logic [XLEN-1:0]     data_t;

    // Occupancy counters hold one more value than the pointers
    typedef logic [GL_IDX_W:0]   gl_count_t;
    typedef logic [FL_PTR_W-1:0] fl_ptr_t;
    typedef logic [FL_PTR_W:0]   fl_count_t;

endpackage

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
/*
 * Bundles passed between rename, writeback and commit.
 * Decode feeds decode_instr_t in, results come back as wb_req_t and
 * retired instructions leave as commit_t.
 */

`default_nettype none

package pipe_pkg;

    // Instruction as it leaves decode
    typedef struct packed {
        logic                  valid;
        rename_cfg_pkg::reg_t  rd;
        rename_cfg_pkg::reg_t  rs1;
        rename_cfg_pkg::reg_t  rs2;
        logic                  regfile_we;
    } decode_instr_t;

    // Decoded fields plus the physical mapping and operand readiness
    typedef struct packed {
        logic                      valid;
        rename_cfg_pkg::reg_t      rd;
        rename_cfg_pkg::reg_t      rs1;
        rename_cfg_pkg::reg_t      rs2;
        logic                      regfile_we;
        rename_cfg_pkg::phreg_t    prd;
        rename_cfg_pkg::phreg_t    old_prd;
        rename_cfg_pkg::phreg_t    prs1;
        rename_cfg_pkg::phreg_t    prs2;
        logic                      rdy1;
        logic                      rdy2;
        rename_cfg_pkg::gl_index_t gl_index;
    } renamed_instr_t;

    // Result returned by an execution port
    typedef struct packed {
        logic                      valid;
        rename_cfg_pkg::gl_index_t gl_index;
        rename_cfg_pkg::phreg_t    prd;
        rename_cfg_pkg::data_t     data;
    } wb_req_t;

    // One retired instruction
    typedef struct packed {
        logic                   valid;
        rename_cfg_pkg::reg_t   rd;
        rename_cfg_pkg::phreg_t prd;
        rename_cfg_pkg::phreg_t old_prd;
        logic                   regfile_we;
        rename_cfg_pkg::data_t  data;
    } commit_t;

endpackage

`default_nettype wire

// ==== logic/wb_arbiter.sv ====
/*
 * Fixed-priority arbiter for the single register file write port.
 * ALU results win over memory results; a losing port holds its request.
 */

`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  pipe_pkg::wb_req_t alu_i,
    input  pipe_pkg::wb_req_t mem_i,
    output logic              alu_grant_o,
    output logic              mem_grant_o,
    output pipe_pkg::wb_req_t wb_o
);

    assign alu_grant_o = alu_i.valid;
    assign mem_grant_o = mem_i.valid & ~alu_i.valid;

    // Idle path carries an all-zero, invalid request
    always_comb begin
        if (alu_grant_o) begin
            wb_o = alu_i;
        end else if (mem_grant_o) begin
            wb_o = mem_i;
        end else begin
            wb_o = '0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/phys_regfile.sv ====
/*
 * Physical register file, one write port fed by the writeback arbiter
 * and two combinational read ports that see a same-cycle write.
 */

`timescale 1ns/1ps
`default_nettype none

module phys_regfile (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  pipe_pkg::wb_req_t      wb_i,
    input  rename_cfg_pkg::phreg_t raddr1_i,
    input  rename_cfg_pkg::phreg_t raddr2_i,
    output rename_cfg_pkg::data_t  rdata1_o,
    output rename_cfg_pkg::data_t  rdata2_o
);

    import rename_cfg_pkg::*;

    data_t regs_q [NUM_PHYS_REGS];

    // Register 0 reads as zero, a write in flight is forwarded
    function automatic data_t read_port(phreg_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_i.valid && (wb_i.prd == addr)) begin
            return wb_i.data;
        end
        return regs_q[addr];
    endfunction

    always_comb begin
        rdata1_o = read_port(raddr1_i);
        rdata2_o = read_port(raddr2_i);
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.valid && (wb_i.prd != '0)) begin
            regs_q[wb_i.prd] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/free_list.sv ====
/*
 * Circular queue of unallocated physical registers.
 * Rename pops the head, commit pushes freed registers at the tail.
 */

`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   pop_i,
    input  logic                   push_i,
    input  rename_cfg_pkg::phreg_t push_reg_i,
    output rename_cfg_pkg::phreg_t head_o,
    output logic                   empty_o
);

    import rename_cfg_pkg::*;

    phreg_t    fifo_q [FREE_LIST_DEPTH];
    fl_ptr_t   head_q;
    fl_ptr_t   tail_q;
    fl_count_t count_q;

    assign head_o  = fifo_q[head_q];
    assign empty_o = (count_q == '0);

    // Starts full with every register above the architectural range
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < FREE_LIST_DEPTH; i++) begin
                fifo_q[i] <= phreg_t'(NUM_ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= fl_count_t'(FREE_LIST_DEPTH);
        end else begin
            if (push_i) begin
                fifo_q[tail_q] <= push_reg_i;
                tail_q         <= tail_q + 1'b1;
            end
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + fl_count_t'(push_i) - fl_count_t'(pop_i);
        end
    end

endmodule

`default_nettype wire

// ==== logic/rename_map.sv ====
/*
 * Speculative architectural-to-physical map and the per-register ready
 * table. Read combinationally by rename, written on allocation and
 * writeback.
 */

`timescale 1ns/1ps
`default_nettype none

module rename_map (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  rename_cfg_pkg::reg_t   rs1_i,
    input  rename_cfg_pkg::reg_t   rs2_i,
    input  rename_cfg_pkg::reg_t   rd_i,
    input  logic                   alloc_i,
    input  rename_cfg_pkg::phreg_t new_prd_i,
    input  pipe_pkg::wb_req_t      wb_i,
    output rename_cfg_pkg::phreg_t prs1_o,
    output rename_cfg_pkg::phreg_t prs2_o,
    output rename_cfg_pkg::phreg_t old_prd_o,
    output logic                   rdy1_o,
    output logic                   rdy2_o
);

    import rename_cfg_pkg::*;

    phreg_t                   map_q [NUM_ARCH_REGS];
    logic [NUM_PHYS_REGS-1:0] ready_q;

    assign prs1_o    = map_q[rs1_i];
    assign prs2_o    = map_q[rs2_i];
    assign old_prd_o = map_q[rd_i];
    assign rdy1_o    = ready_q[prs1_o];
    assign rdy2_o    = ready_q[prs2_o];

    // Identity mapping out of reset, everything ready
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_q[i] <= phreg_t'(i);
            end
            ready_q <= '1;
        end else begin
            if (alloc_i) begin
                map_q[rd_i]          <= new_prd_i;
                ready_q[new_prd_i] <= 1'b0;
            end
            if (wb_i.valid) begin
                ready_q[wb_i.prd] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/graduation_list.sv ====
/*
 * In-order completion buffer. Entries are inserted at rename, marked done
 * by writeback through their index and retired one per cycle from the
 * head. The head entry drives commit_o while it is done.
 */

`timescale 1ns/1ps
`default_nettype none

module graduation_list (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  pipe_pkg::renamed_instr_t  insert_i,
    input  pipe_pkg::wb_req_t         wb_i,
    output rename_cfg_pkg::gl_index_t tail_o,
    output logic                      full_o,
    output pipe_pkg::commit_t         commit_o
);

    import rename_cfg_pkg::*;
    import pipe_pkg::*;

    commit_t             entry_q [GL_DEPTH];
    logic [GL_DEPTH-1:0] done_q;
    gl_index_t           head_q;
    gl_index_t           tail_q;
    gl_count_t           count_q;
    logic                retire;

    assign tail_o = tail_q;
    assign full_o = (count_q == gl_count_t'(GL_DEPTH));
    assign retire = (count_q != '0) && done_q[head_q];

    always_comb begin
        commit_o       = entry_q[head_q];
        commit_o.valid = retire;
    end

    //////////////////////////////////////////////////
    // Pointers and done flags
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (insert_i.valid) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            // A result never targets the slot being inserted
            if (wb_i.valid) begin
                done_q[wb_i.gl_index] <= 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + gl_count_t'(insert_i.valid) - gl_count_t'(retire);
        end
    end

    //////////////////////////////////////////////////
    // Entry payload
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (insert_i.valid) begin
            entry_q[tail_q].rd         <= insert_i.rd;
            entry_q[tail_q].prd        <= insert_i.prd;
            entry_q[tail_q].old_prd    <= insert_i.old_prd;
            entry_q[tail_q].regfile_we <= insert_i.regfile_we;
        end
        if (wb_i.valid) begin
            entry_q[wb_i.gl_index].data <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rename_stage.sv ====
/*
 * Rename stage. Decides acceptance and stall, allocates the destination,
 * inserts into the graduation list and holds the renamed instruction for
 * one cycle while snooping the writeback path for operand readiness.
 */

`timescale 1ns/1ps
`default_nettype none

module rename_stage (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  pipe_pkg::decode_instr_t   decode_i,
    input  logic                      free_empty_i,
    input  rename_cfg_pkg::phreg_t    free_head_i,
    input  logic                      gl_full_i,
    input  rename_cfg_pkg::gl_index_t gl_tail_i,
    input  rename_cfg_pkg::phreg_t    map_prs1_i,
    input  rename_cfg_pkg::phreg_t    map_prs2_i,
    input  rename_cfg_pkg::phreg_t    map_old_prd_i,
    input  logic                      map_rdy1_i,
    input  logic                      map_rdy2_i,
    input  pipe_pkg::wb_req_t         wb_i,
    output logic                      alloc_o,
    output pipe_pkg::renamed_instr_t  insert_o,
    output logic                      stall_o,
    output pipe_pkg::renamed_instr_t  renamed_o
);

    import rename_cfg_pkg::*;
    import pipe_pkg::*;

    logic           need_reg;
    logic           accept;
    logic           out_valid_q;
    renamed_instr_t out_q;

    // x0 is hardwired, so it never waits on a producer
    function automatic logic snoop(wb_req_t wb, phreg_t prs, reg_t rs);
        return wb.valid && (wb.prd == prs) && (rs != '0);
    endfunction

    assign need_reg = decode_i.valid & decode_i.regfile_we & (decode_i.rd != '0);
    assign stall_o  = gl_full_i | (free_empty_i & need_reg);
    assign accept   = decode_i.valid & ~stall_o;
    assign alloc_o  = accept & need_reg;

    // Renamed view of the instruction in the accept cycle
    always_comb begin
        insert_o.valid      = accept;
        insert_o.rd         = decode_i.rd;
        insert_o.rs1        = decode_i.rs1;
        insert_o.rs2        = decode_i.rs2;
        insert_o.regfile_we = decode_i.regfile_we;
        insert_o.prd        = need_reg ? free_head_i : '0;
        insert_o.old_prd    = need_reg ? map_old_prd_i : '0;
        insert_o.prs1       = map_prs1_i;
        insert_o.prs2       = map_prs2_i;
        insert_o.rdy1       = map_rdy1_i | snoop(wb_i, map_prs1_i, decode_i.rs1);
        insert_o.rdy2       = map_rdy2_i | snoop(wb_i, map_prs2_i, decode_i.rs2);
        insert_o.gl_index   = gl_tail_i;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        out_q <= insert_o;
    end

    // Ready table missed any writeback granted during this cycle
    always_comb begin
        renamed_o       = out_q;
        renamed_o.valid = out_valid_q;
        renamed_o.rdy1  = out_q.rdy1 | snoop(wb_i, out_q.prs1, out_q.rs1);
        renamed_o.rdy2  = out_q.rdy2 | snoop(wb_i, out_q.prs2, out_q.rs2);
    end

endmodule

`default_nettype wire

// ==== logic/rename_core_top.sv ====
/*
 * Rename, writeback and retirement back end.
 * Takes one decoded instruction per cycle, shares the register file write
 * port between the ALU and memory result ports and retires in order.
 */

`timescale 1ns/1ps
`default_nettype none

module rename_core_top (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  pipe_pkg::decode_instr_t decode_i,
    input  pipe_pkg::wb_req_t       wb_alu_i,
    input  pipe_pkg::wb_req_t       wb_mem_i,
    output logic                     stall_o,
    output pipe_pkg::renamed_instr_t renamed_o,
    output rename_cfg_pkg::data_t    rs1_data_o,
    output rename_cfg_pkg::data_t    rs2_data_o,
    output logic                     wb_alu_grant_o,
    output logic                     wb_mem_grant_o,
    output pipe_pkg::commit_t        commit_o
);

    import rename_cfg_pkg::*;
    import pipe_pkg::*;

    logic           free_empty;
    phreg_t         free_head;
    logic           alloc;
    logic           gl_full;
    gl_index_t      gl_tail;
    phreg_t         map_prs1;
    phreg_t         map_prs2;
    phreg_t         map_old_prd;
    logic           map_rdy1;
    logic           map_rdy2;
    renamed_instr_t insert;
    wb_req_t        wb_win;

    //////////////////////////////////////////////////
    // Rename
    //////////////////////////////////////////////////

    rename_stage rename_stage_inst (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .decode_i      (decode_i),
        .free_empty_i  (free_empty),
        .free_head_i   (free_head),
        .gl_full_i     (gl_full),
        .gl_tail_i     (gl_tail),
        .map_prs1_i    (map_prs1),
        .map_prs2_i    (map_prs2),
        .map_old_prd_i (map_old_prd),
        .map_rdy1_i    (map_rdy1),
        .map_rdy2_i    (map_rdy2),
        .wb_i          (wb_win),
        .alloc_o       (alloc),
        .insert_o      (insert),
        .stall_o       (stall_o),
        .renamed_o     (renamed_o)
    );

    rename_map rename_map_inst (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .rs1_i     (decode_i.rs1),
        .rs2_i     (decode_i.rs2),
        .rd_i      (decode_i.rd),
        .alloc_i   (alloc),
        .new_prd_i (free_head),
        .wb_i      (wb_win),
        .prs1_o    (map_prs1),
        .prs2_o    (map_prs2),
        .old_prd_o (map_old_prd),
        .rdy1_o    (map_rdy1),
        .rdy2_o    (map_rdy2)
    );

    // Old mapping of a real destination goes back to the pool at commit
    free_list free_list_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .pop_i      (alloc),
        .push_i     (commit_o.valid & commit_o.regfile_we & (commit_o.rd != '0)),
        .push_reg_i (commit_o.old_prd),
        .head_o     (free_head),
        .empty_o    (free_empty)
    );

    //////////////////////////////////////////////////
    // Writeback and retirement
    //////////////////////////////////////////////////

    wb_arbiter wb_arbiter_inst (
        .alu_i       (wb_alu_i),
        .mem_i       (wb_mem_i),
        .alu_grant_o (wb_alu_grant_o),
        .mem_grant_o (wb_mem_grant_o),
        .wb_o        (wb_win)
    );

    phys_regfile phys_regfile_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .wb_i     (wb_win),
        .raddr1_i (renamed_o.prs1),
        .raddr2_i (renamed_o.prs2),
        .rdata1_o (rs1_data_o),
        .rdata2_o (rs2_data_o)
    );

    graduation_list graduation_list_inst (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .insert_i (insert),
        .wb_i     (wb_win),
        .tail_o   (gl_tail),
        .full_o   (gl_full),
        .commit_o (commit_o)
    );

endmodule

`default_nettype wire

// ==== test/tb_rename_core.sv ====
/*
 * Testbench for the rename back end. Applies a table of instructions,
 * returns their results on the ALU and memory ports after random delays and
 * checks mapping, operand readiness, stall and commit order against a model.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_rename_core;

    import rename_cfg_pkg::*;
    import pipe_pkg::*;

    localparam int          CLK_PERIOD = 8;
    localparam int          RST_CYCLES = 16;
    localparam int          NUM_ROWS   = 30;
    localparam logic [31:0] SEED       = 32'hc478_db32;

    // Port 0 picks at random, 1 is ALU, 2 is memory. Latency 0 picks 0..3
    typedef struct packed {
        reg_t       rd;
        reg_t       rs1;
        reg_t       rs2;
        logic       we;
        data_t      value;
        logic [1:0] port;
        logic [7:0] lat;
    } row_t;

    row_t rows [NUM_ROWS] = '{
        // rd     rs1    rs2    we    value                    port  lat
        '{5'd1,  5'd5,  5'd6,  1'b1, 64'h1111_0000_0000_0001, 2'd1, 8'd6},
        '{5'd2,  5'd0,  5'd7,  1'b1, 64'h2222_0000_0000_0002, 2'd2, 8'd2},
        '{5'd3,  5'd1,  5'd2,  1'b1, 64'h3333_0000_0000_0003, 2'd0, 8'd0},
        '{5'd0,  5'd3,  5'd1,  1'b1, 64'h0bad_0000_0000_0004, 2'd0, 8'd0},
        '{5'd7,  5'd8,  5'd9,  1'b0, 64'h0000_7777_0000_0005, 2'd0, 8'd0},
        // Memory result lands on top of a run of ALU results
        '{5'd4,  5'd1,  5'd3,  1'b1, 64'h4444_0000_0000_0006, 2'd1, 8'd1},
        '{5'd1,  5'd1,  5'd4,  1'b1, 64'h1111_1111_0000_0007, 2'd2, 8'd3},
        '{5'd5,  5'd2,  5'd0,  1'b1, 64'h5555_0000_0000_0008, 2'd1, 8'd1},
        '{5'd6,  5'd5,  5'd1,  1'b1, 64'h6666_0000_0000_0009, 2'd1, 8'd1},
        '{5'd8,  5'd6,  5'd7,  1'b1, 64'h8888_0000_0000_000a, 2'd1, 8'd1},
        // Slow head, blocks retirement until both lists run out
        '{5'd9,  5'd8,  5'd1,  1'b1, 64'h9999_0000_0000_000b, 2'd2, 8'd60},
        '{5'd10, 5'd9,  5'd2,  1'b1, 64'ha0a0_0000_0000_000c, 2'd0, 8'd0},
        '{5'd11, 5'd10, 5'd3,  1'b1, 64'ha1a1_0000_0000_000d, 2'd0, 8'd0},
        '{5'd12, 5'd4,  5'd11, 1'b1, 64'ha2a2_0000_0000_000e, 2'd0, 8'd0},
        '{5'd13, 5'd12, 5'd5,  1'b1, 64'ha3a3_0000_0000_000f, 2'd0, 8'd0},
        '{5'd14, 5'd6,  5'd13, 1'b1, 64'ha4a4_0000_0000_0010, 2'd0, 8'd0},
        '{5'd15, 5'd14, 5'd8,  1'b1, 64'ha5a5_0000_0000_0011, 2'd0, 8'd0},
        '{5'd16, 5'd15, 5'd16, 1'b1, 64'ha6a6_0000_0000_0012, 2'd0, 8'd0},
        '{5'd17, 5'd1,  5'd16, 1'b1, 64'ha7a7_0000_0000_0013, 2'd0, 8'd0},
        '{5'd18, 5'd17, 5'd2,  1'b1, 64'ha8a8_0000_0000_0014, 2'd0, 8'd0},
        '{5'd19, 5'd18, 5'd0,  1'b1, 64'ha9a9_0000_0000_0015, 2'd0, 8'd0},
        '{5'd20, 5'd19, 5'd3,  1'b1, 64'haaaa_0000_0000_0016, 2'd0, 8'd0},
        '{5'd21, 5'd20, 5'd4,  1'b1, 64'habab_0000_0000_0017, 2'd0, 8'd0},
        '{5'd22, 5'd21, 5'd5,  1'b1, 64'hacac_0000_0000_0018, 2'd0, 8'd0},
        '{5'd23, 5'd22, 5'd6,  1'b1, 64'hadad_0000_0000_0019, 2'd0, 8'd0},
        '{5'd24, 5'd23, 5'd24, 1'b1, 64'haeae_0000_0000_001a, 2'd0, 8'd0},
        // Stalled, then served from recycled registers
        '{5'd25, 5'd9,  5'd24, 1'b1, 64'hb0b0_0000_0000_001b, 2'd0, 8'd0},
        '{5'd1,  5'd1,  5'd25, 1'b1, 64'hb1b1_0000_0000_001c, 2'd0, 8'd0},
        '{5'd2,  5'd2,  5'd10, 1'b1, 64'hb2b2_0000_0000_001d, 2'd0, 8'd0},
        '{5'd0,  5'd26, 5'd0,  1'b0, 64'hb3b3_0000_0000_001e, 2'd0, 8'd0}
    };

    logic           clk;
    logic           rstn;
    decode_instr_t  decode;
    wb_req_t        wb_alu;
    wb_req_t        wb_mem;
    logic           stall;
    renamed_instr_t renamed;
    data_t          rs1_data;
    data_t          rs2_data;
    logic           alu_grant;
    logic           mem_grant;
    commit_t        commit;

    // Reference model state
    int    map_m [NUM_ARCH_REGS];
    bit    ready_m [NUM_PHYS_REGS];
    data_t pdata_m [NUM_PHYS_REGS];
    int    free_m [$];
    int    gl_m [$];
    int    pend [$];
    bit    done_m [NUM_ROWS];
    int    port_m [NUM_ROWS];
    int    elig [NUM_ROWS];
    int    exp_prd [NUM_ROWS];
    int    exp_old [NUM_ROWS];
    int    exp_prs1 [NUM_ROWS];
    int    exp_prs2 [NUM_ROWS];
    int    exp_gl [NUM_ROWS];
    int    alu_row;
    int    mem_row;
    int    out_row;
    int    next_row;
    int    accepted;
    int    retired;
    int    cycle;
    int    checks;
    int    errors;
    int    conflicts;
    int    stalls;

    rename_core_top i_dut (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .decode_i       (decode),
        .wb_alu_i       (wb_alu),
        .wb_mem_i       (wb_mem),
        .stall_o        (stall),
        .renamed_o      (renamed),
        .rs1_data_o     (rs1_data),
        .rs2_data_o     (rs2_data),
        .wb_alu_grant_o (alu_grant),
        .wb_mem_grant_o (mem_grant),
        .commit_o       (commit)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    function automatic bit needs_reg(int r);
        return rows[r].we && (rows[r].rd != '0);
    endfunction

    function automatic wb_req_t result_of(int r);
        wb_req_t req;
        req.valid    = 1'b1;
        req.gl_index = gl_index_t'(exp_gl[r]);
        req.prd      = phreg_t'(exp_prd[r]);
        req.data     = rows[r].value;
        return req;
    endfunction

    // Oldest pending result for this port whose delay has run out
    function automatic int take_ready(int port);
        int r;
        r = -1;
        for (int i = 0; i < pend.size() && r < 0; i++) begin
            if (port_m[pend[i]] == port && elig[pend[i]] <= cycle) begin
                r = pend[i];
                pend.delete(i);
            end
        end
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Per-cycle check and model update
    //////////////////////////////////////////////////

    task automatic check_and_advance();
        wb_req_t win;
        int      wrow;
        int      r;
        int      freed;
        logic    exp_stall;
        logic    exp_alu_grant;
        logic    exp_mem_grant;
        logic    commit_exp;
        logic    e_rdy1;
        logic    e_rdy2;
        data_t   e_d1;
        data_t   e_d2;

        exp_stall = (gl_m.size() == GL_DEPTH) ||
                    (next_row < NUM_ROWS && free_m.size() == 0 && needs_reg(next_row));
        check_value("stall_o", 64'(stall), 64'(exp_stall));
        exp_alu_grant = (alu_row >= 0);
        exp_mem_grant = (mem_row >= 0) && (alu_row < 0);
        check_value("wb_alu_grant_o", 64'(alu_grant), 64'(exp_alu_grant));
        check_value("wb_mem_grant_o", 64'(mem_grant), 64'(exp_mem_grant));
        if (alu_row >= 0 && mem_row >= 0) conflicts++;
        if (exp_stall && next_row < NUM_ROWS) stalls++;
        // ALU has priority on the shared write port
        wrow = exp_alu_grant ? alu_row : mem_row;
        win  = (wrow >= 0) ? result_of(wrow) : '0;

        check_value("renamed_o.valid", 64'(renamed.valid), 64'(out_row >= 0));
        if (out_row >= 0) begin
            r = out_row;
            e_rdy1 = ready_m[exp_prs1[r]] ||
                     (win.valid && int'(win.prd) == exp_prs1[r] && rows[r].rs1 != '0);
            e_rdy2 = ready_m[exp_prs2[r]] ||
                     (win.valid && int'(win.prd) == exp_prs2[r] && rows[r].rs2 != '0);
            e_d1 = (win.valid && exp_prs1[r] != 0 && int'(win.prd) == exp_prs1[r]) ?
                   win.data : pdata_m[exp_prs1[r]];
            e_d2 = (win.valid && exp_prs2[r] != 0 && int'(win.prd) == exp_prs2[r]) ?
                   win.data : pdata_m[exp_prs2[r]];
            check_value("renamed_o.rd", 64'(renamed.rd), 64'(rows[r].rd));
            check_value("renamed_o.rs1", 64'(renamed.rs1), 64'(rows[r].rs1));
            check_value("renamed_o.rs2", 64'(renamed.rs2), 64'(rows[r].rs2));
            check_value("renamed_o.regfile_we", 64'(renamed.regfile_we), 64'(rows[r].we));
            check_value("renamed_o.prd", 64'(renamed.prd), 64'(exp_prd[r]));
            check_value("renamed_o.old_prd", 64'(renamed.old_prd), 64'(exp_old[r]));
            check_value("renamed_o.prs1", 64'(renamed.prs1), 64'(exp_prs1[r]));
            check_value("renamed_o.prs2", 64'(renamed.prs2), 64'(exp_prs2[r]));
            check_value("renamed_o.gl_index", 64'(renamed.gl_index), 64'(exp_gl[r]));
            check_value("renamed_o.rdy1", 64'(renamed.rdy1), 64'(e_rdy1));
            check_value("renamed_o.rdy2", 64'(renamed.rdy2), 64'(e_rdy2));
            if (e_rdy1) check_value("rs1_data_o", rs1_data, e_d1);
            if (e_rdy2) check_value("rs2_data_o", rs2_data, e_d2);
            // Hand the result to an execution port
            port_m[r] = (rows[r].port == 2'd0) ? int'($urandom_range(1, 2)) : int'(rows[r].port);
            elig[r]   = cycle + ((rows[r].lat == 8'd0) ? int'($urandom_range(0, 3))
                                                       : int'(rows[r].lat));
            pend.push_back(r);
        end

        freed = -1;
        commit_exp = (gl_m.size() > 0) && done_m[gl_m[0]];
        check_value("commit_o.valid", 64'(commit.valid), 64'(commit_exp));
        if (commit_exp) begin
            r = gl_m.pop_front();
            check_value("commit_o.rd", 64'(commit.rd), 64'(rows[r].rd));
            check_value("commit_o.prd", 64'(commit.prd), 64'(exp_prd[r]));
            check_value("commit_o.old_prd", 64'(commit.old_prd), 64'(exp_old[r]));
            check_value("commit_o.regfile_we", 64'(commit.regfile_we), 64'(rows[r].we));
            check_value("commit_o.data", commit.data, rows[r].value);
            if (needs_reg(r)) freed = exp_old[r];
            retired++;
        end

        if (win.valid) begin
            done_m[wrow] = 1'b1;
            ready_m[exp_prd[wrow]] = 1'b1;
            if (exp_prd[wrow] != 0) pdata_m[exp_prd[wrow]] = rows[wrow].value;
            if (exp_alu_grant) alu_row = -1;
            else mem_row = -1;
        end

        out_row = -1;
        if (next_row < NUM_ROWS && !exp_stall) begin
            r = next_row;
            exp_prs1[r] = map_m[rows[r].rs1];
            exp_prs2[r] = map_m[rows[r].rs2];
            exp_gl[r]   = accepted % GL_DEPTH;
            exp_prd[r]  = 0;
            exp_old[r]  = 0;
            if (needs_reg(r)) begin
                exp_prd[r] = free_m.pop_front();
                exp_old[r] = map_m[rows[r].rd];
                map_m[rows[r].rd] = exp_prd[r];
                ready_m[exp_prd[r]] = 1'b0;
            end
            gl_m.push_back(r);
            accepted++;
            next_row++;
            out_row = r;
        end
        if (freed >= 0) free_m.push_back(freed);
    endtask

    task automatic drive_inputs();
        if (alu_row < 0) alu_row = take_ready(1);
        if (mem_row < 0) mem_row = take_ready(2);
        wb_alu <= (alu_row >= 0) ? result_of(alu_row) : '0;
        wb_mem <= (mem_row >= 0) ? result_of(mem_row) : '0;
        if (next_row < NUM_ROWS) begin
            decode <= '{1'b1, rows[next_row].rd, rows[next_row].rs1,
                        rows[next_row].rs2, rows[next_row].we};
        end else begin
            decode <= '0;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        rstn   <= 1'b0;
        decode <= '0;
        wb_alu <= '0;
        wb_mem <= '0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) map_m[i] = i;
        for (int i = 0; i < NUM_PHYS_REGS; i++) begin
            ready_m[i] = 1'b1;
            pdata_m[i] = '0;
        end
        for (int i = 0; i < FREE_LIST_DEPTH; i++) free_m.push_back(NUM_ARCH_REGS + i);
        alu_row   = -1;
        mem_row   = -1;
        out_row   = -1;
        next_row  = 0;
        accepted  = 0;
        retired   = 0;
        cycle     = 0;
        checks    = 0;
        errors    = 0;
        conflicts = 0;
        stalls    = 0;

        repeat (RST_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_value("stall_o", 64'(stall), 64'd0);
        check_value("wb_alu_grant_o", 64'(alu_grant), 64'd0);
        check_value("wb_mem_grant_o", 64'(mem_grant), 64'd0);
        check_value("renamed_o.valid", 64'(renamed.valid), 64'd0);
        check_value("commit_o.valid", 64'(commit.valid), 64'd0);
        @(posedge clk);
        rstn <= 1'b1;
        drive_inputs();

        while (retired < NUM_ROWS) begin
            @(negedge clk);
            check_and_advance();
            @(posedge clk);
            cycle++;
            drive_inputs();
        end

        if (conflicts == 0) begin
            errors++;
            $display("The two result ports never requested in the same cycle");
        end
        if (stalls == 0) begin
            errors++;
            $display("No instruction was ever held back by a stall");
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Generous bound of 40 cycles per table row
    initial begin
        #(CLK_PERIOD * (RST_CYCLES + NUM_ROWS * 40));
        $display("Timeout: only %0d of %0d instructions retired", retired, NUM_ROWS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/rename_cfg_pkg.sv
logic/pipe_pkg.sv
logic/wb_arbiter.sv
logic/phys_regfile.sv
logic/free_list.sv
logic/rename_map.sv
logic/graduation_list.sv
logic/rename_stage.sv
logic/rename_core_top.sv
test/tb_rename_core.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f project.f --top-module tb_rename_core -o sim \
    && ./obj_dir/sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -qx "RESULT: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
